/* fetch_stage.f */
hdl/fetch_pkg.sv
hdl/fetch_region_check.sv
hdl/fetch_buffer.sv
hdl/fetch_addr_stage.sv
hdl/fetch_stage.sv
test/fetch_stage_tb.sv

/* hdl/fetch_addr_stage.sv */
`timescale 1ns/1ps
`default_nettype none
//**************************************************************************
// Fetch address stage
// FE0 address phase and FE1 data phase registers, next fetch address,
// AHB-Lite request outputs and the push into the instruction buffer
//**************************************************************************

module fetch_addr_stage #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
) (
    input  wire logic                          s_clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          s_flush_i,       // Redirect pulse
    input  wire logic [fetch_pkg::XLEN-1:0]    s_toc_addr_i,    // Redirect target
    input  wire logic                          s_hready_i,
    input  wire logic                          s_hresp_i,
    input  wire logic [fetch_pkg::XLEN-1:0]    s_hrdata_i,
    input  wire logic                          violation_i,     // FE0 outside region
    input  wire logic                          space_first_i,   // Buffer empty
    input  wire logic                          space_one_i,
    input  wire logic                          space_two_i,
    input  wire logic                          space_three_i,
    output logic [fetch_pkg::WADDR_W-1:0]      fe0_addr_o,
    output logic [fetch_pkg::XLEN-1:0]         s_haddr_o,
    output logic [1:0]                         s_htrans_o,
    output logic                               push_o,
    output logic [fetch_pkg::XLEN-1:0]         push_data_o,
    output fetch_pkg::fetch_status_t           push_status_o
);

    logic [fetch_pkg::WADDR_W-1:0] fe0_addr_q, fe0_addr_d;
    logic                          fe0_utd_q, fe0_utd_d;    // FE0 data will be needed
    logic [fetch_pkg::WADDR_W-1:0] fe1_addr_q, fe1_addr_d;
    logic                          fe1_utd_q, fe1_utd_d;    // FE1 data will be needed
    fetch_pkg::fe1_code_t          fe1_code_q, fe1_code_d;
    logic [fetch_pkg::WADDR_W-1:0] toc_waddr;
    logic                          fe0_frozen;
    logic                          toc_in_fe1;
    logic                          no_xfer_fe1;
    logic                          space_ok;

    assign toc_waddr   = s_toc_addr_i[fetch_pkg::XLEN-1:2];
    assign fe0_frozen  = ~s_hready_i & fe0_utd_q;   // Request held by a wait state
    assign toc_in_fe1  = ~fe1_utd_q & (fe1_code_q == fetch_pkg::FE1_SPECIAL);  // Parked redirect
    assign no_xfer_fe1 = fe1_utd_q & (fe1_code_q == fetch_pkg::FE1_SPECIAL);   // Region violation

    // Issue only with room for the data on arrival
    // Empty buffer, or one entry with both phases idle, two with one idle, else three
    assign space_ok = space_first_i
                    | (space_one_i & ~fe0_utd_q & ~fe1_utd_q)
                    | (space_two_i & (~fe0_utd_q | ~fe1_utd_q))
                    | space_three_i;

    // Bus request
    assign fe0_addr_o = fe0_addr_q;
    assign s_haddr_o  = {fe0_addr_q, 2'b00};
    assign s_htrans_o = (fe0_utd_q && !violation_i) ? fetch_pkg::HTRANS_NONSEQ
                                                    : fetch_pkg::HTRANS_IDLE;

    // Buffer push where a violation carries no bus data
    assign push_o      = s_hready_i & fe1_utd_q;
    assign push_data_o = no_xfer_fe1 ? '0 : s_hrdata_i;

    always_comb begin
        if (no_xfer_fe1)   push_status_o = fetch_pkg::FETCH_PMA_VIOL;
        else if (s_hresp_i) push_status_o = fetch_pkg::FETCH_BUS_ERR;
        else               push_status_o = fetch_pkg::FETCH_VALID;
    end

    always_comb begin : fe1_update
        fe1_addr_d = fe1_addr_q;
        fe1_utd_d  = fe1_utd_q;
        fe1_code_d = fe1_code_q;
        if (s_flush_i && fe0_frozen) begin
            fe1_addr_d = toc_waddr;       // FE0 may not move so the target parks here
            fe1_utd_d  = 1'b0;
            fe1_code_d = fetch_pkg::FE1_SPECIAL;
        end else if (s_flush_i || (s_hready_i && toc_in_fe1)) begin
            fe1_utd_d  = 1'b0;            // Data phase no longer wanted
            fe1_code_d = fetch_pkg::FE1_NONE;
        end else if (s_hready_i) begin
            fe1_addr_d = fe0_addr_q;      // Address phase moves into data phase
            fe1_utd_d  = fe0_utd_q;
            if (violation_i && fe0_utd_q) fe1_code_d = fetch_pkg::FE1_SPECIAL;
            else                          fe1_code_d = fetch_pkg::FE1_NONE;
        end
    end

    always_comb begin : fe0_update
        if (fe0_frozen) begin
            fe0_addr_d = fe0_addr_q;      // No change until the bus accepts it
            fe0_utd_d  = 1'b1;
        end else if (s_flush_i) begin
            fe0_addr_d = toc_waddr;
            fe0_utd_d  = 1'b1;
        end else if (toc_in_fe1) begin
            fe0_addr_d = fe1_addr_q;      // Apply redirect parked during the wait
            fe0_utd_d  = 1'b1;
        end else if (fe0_utd_q) begin
            fe0_addr_d = fe0_addr_q + fetch_pkg::WADDR_W'(1);  // Next word
            fe0_utd_d  = space_ok;
        end else begin
            fe0_addr_d = fe0_addr_q;      // Wait for buffer room
            fe0_utd_d  = space_ok;
        end
    end

    // First request goes out once reset is released
    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            fe0_addr_q <= RESET_ADDR[fetch_pkg::XLEN-1:2];
            fe0_utd_q  <= 1'b0;
            fe1_utd_q  <= 1'b0;
            fe1_code_q <= fetch_pkg::FE1_NONE;
        end else begin
            fe0_addr_q <= fe0_addr_d;
            fe0_utd_q  <= fe0_utd_d;
            fe1_utd_q  <= fe1_utd_d;
            fe1_code_q <= fe1_code_d;
        end
    end

    always_ff @(posedge s_clk_i) begin
        fe1_addr_q <= fe1_addr_d;         // FE1 address or parked redirect target
    end

    // A request stretched by wait states keeps address and type until accepted
    a_req_stable: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        (s_htrans_o == fetch_pkg::HTRANS_NONSEQ && !s_hready_i) |=>
        ($stable(s_haddr_o) && $stable(s_htrans_o)));

endmodule

`default_nettype wire

/* hdl/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
//**************************************************************************
// Fetch instruction buffer
// Circular FIFO between fetch and decode with a thermometer occupancy,
// flush and the free space flags used by the fetch space rule
//**************************************************************************

module fetch_buffer #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                          s_clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          s_flush_i,      // Redirect, drop everything
    input  wire logic                          push_i,
    input  wire logic [fetch_pkg::XLEN-1:0]    push_data_i,
    input  wire fetch_pkg::fetch_status_t      push_status_i,
    input  wire logic                          s_stall_i,      // Decode holds the head
    output logic [fetch_pkg::XLEN-1:0]         s_instr_o,
    output fetch_pkg::fetch_status_t           s_status_o,
    output logic                               s_valid_o,
    output logic                               space_first_o,  // Buffer empty
    output logic                               space_one_o,    // At least one free entry
    output logic                               space_two_o,
    output logic                               space_three_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [fetch_pkg::XLEN-1:0] instr_mem [FIFO_DEPTH];
    fetch_pkg::fetch_status_t   status_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [PTR_W-1:0]           wr_ptr_nxt;
    logic [PTR_W-1:0]           rd_ptr_nxt;
    logic [FIFO_DEPTH-1:0]      occ_q;       // Bit k set when more than k entries held
    logic                       wr_en;
    logic                       rd_en;

    assign wr_en = push_i & ~s_flush_i;  // Old path data never enters
    assign rd_en = occ_q[0] & ~s_stall_i;

    // Pointers wrap at the depth, which need not be a power of two
    assign wr_ptr_nxt = (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
    assign rd_ptr_nxt = (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || s_flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_nxt;
            if (rd_en) rd_ptr_q <= rd_ptr_nxt;
            case ({wr_en, rd_en})
                2'b10:   occ_q <= {occ_q[FIFO_DEPTH-2:0], 1'b1};  // Grow by one
                2'b01:   occ_q <= {1'b0, occ_q[FIFO_DEPTH-1:1]};  // Shrink by one
                default: occ_q <= occ_q;                         // Both or neither
            endcase
        end
    end

    // Storage, written at the tail
    always_ff @(posedge s_clk_i) begin
        if (wr_en) begin
            instr_mem[wr_ptr_q]  <= push_data_i;
            status_mem[wr_ptr_q] <= push_status_i;
        end
    end

    assign s_instr_o  = instr_mem[rd_ptr_q];   // Head entry
    assign s_status_o = status_mem[rd_ptr_q];
    assign s_valid_o  = occ_q[0];

    // Free space read straight off the thermometer
    assign space_first_o = ~occ_q[0];
    assign space_one_o   = ~occ_q[FIFO_DEPTH-1];
    assign space_two_o   = ~occ_q[FIFO_DEPTH-2];
    assign space_three_o = ~occ_q[FIFO_DEPTH-3];

    // Space reserved by the address stage before issue keeps the buffer from overflowing
    a_no_overflow: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        push_i |-> !occ_q[FIFO_DEPTH-1]);

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none
//**************************************************************************
// Fetch package
// Shared widths, buffer status codes, FE1 phase codes and the bus
// transfer codes of the instruction fetch stage
//**************************************************************************

package fetch_pkg;

    localparam int XLEN    = 32;        // Address and data width
    localparam int WADDR_W = XLEN - 2;  // Word address, fetch is word aligned

    // Status stored with every word in the instruction buffer
    typedef enum logic [2:0] {
        FETCH_VALID    = 3'b000,  // Regular instruction word
        FETCH_BUS_ERR  = 3'b001,  // Bus answered with an error response
        FETCH_PMA_VIOL = 3'b010   // Address outside the executable region
    } fetch_status_t;

    // Extra information held next to the FE1 address
    // SPECIAL reads as a parked redirect while FE1 is not up to date,
    // and as a region violation while it is
    typedef enum logic [1:0] {
        FE1_NONE    = 2'b00,
        FE1_SPECIAL = 2'b11
    } fe1_code_t;

    // AHB-Lite transfer types used by the fetch master
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;  // Single read, no bursts

endpackage

`default_nettype wire

/* hdl/fetch_region_check.sv */
`timescale 1ns/1ps
`default_nettype none
//**************************************************************************
// Fetch region check
// Flags an FE0 word address that lies outside the executable region
//**************************************************************************

module fetch_region_check #(
    parameter logic [fetch_pkg::XLEN-1:0] REGION_BASE = 32'h0000_0000,
    parameter logic [fetch_pkg::XLEN-1:0] REGION_MASK = 32'hFFFF_0000
) (
    input  wire logic [fetch_pkg::WADDR_W-1:0] addr_i,       // FE0 word address
    output logic                               violation_o   // Outside the region
);

    // Byte offset bits drop out, the compare runs on word addresses
    localparam logic [fetch_pkg::WADDR_W-1:0] BASE_W = REGION_BASE[fetch_pkg::XLEN-1:2];
    localparam logic [fetch_pkg::WADDR_W-1:0] MASK_W = REGION_MASK[fetch_pkg::XLEN-1:2];

    logic [fetch_pkg::WADDR_W-1:0] masked_addr;

    assign masked_addr = addr_i & MASK_W;  // Keep only the region selecting bits

    // Inside when the selected bits match the base
    assign violation_o = (masked_addr != BASE_W);

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none
//**************************************************************************
// Fetch stage
// Two phase AHB-Lite instruction fetch with region check and an
// instruction buffer towards decode
//**************************************************************************

module fetch_stage #(
    parameter int                         FIFO_DEPTH  = 4,
    parameter logic [fetch_pkg::XLEN-1:0] RESET_ADDR  = 32'h0000_0000,
    parameter logic [fetch_pkg::XLEN-1:0] REGION_BASE = 32'h0000_0000,
    parameter logic [fetch_pkg::XLEN-1:0] REGION_MASK = 32'hFFFF_0000
) (
    input  wire logic                          s_clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          s_flush_i,     // From execute
    input  wire logic [fetch_pkg::XLEN-1:0]    s_toc_addr_i,
    input  wire logic                          s_stall_i,     // From decode
    input  wire logic                          s_hready_i,
    input  wire logic                          s_hresp_i,
    input  wire logic [fetch_pkg::XLEN-1:0]    s_hrdata_i,
    output logic [fetch_pkg::XLEN-1:0]         s_haddr_o,
    output logic [1:0]                         s_htrans_o,
    output logic [fetch_pkg::XLEN-1:0]         s_instr_o,     // Head of the buffer
    output fetch_pkg::fetch_status_t           s_status_o,
    output logic                               s_valid_o
);

    logic [fetch_pkg::WADDR_W-1:0] fe0_addr;
    logic                          violation;
    logic                          push;
    logic [fetch_pkg::XLEN-1:0]    push_data;
    fetch_pkg::fetch_status_t      push_status;
    logic                          space_first;
    logic                          space_one;
    logic                          space_two;
    logic                          space_three;

    fetch_addr_stage #(
        .RESET_ADDR (RESET_ADDR)
    ) u_addr_stage (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .s_flush_i     (s_flush_i),
        .s_toc_addr_i  (s_toc_addr_i),
        .s_hready_i    (s_hready_i),
        .s_hresp_i     (s_hresp_i),
        .s_hrdata_i    (s_hrdata_i),
        .violation_i   (violation),
        .space_first_i (space_first),
        .space_one_i   (space_one),
        .space_two_i   (space_two),
        .space_three_i (space_three),
        .fe0_addr_o    (fe0_addr),
        .s_haddr_o     (s_haddr_o),
        .s_htrans_o    (s_htrans_o),
        .push_o        (push),
        .push_data_o   (push_data),
        .push_status_o (push_status)
    );

    fetch_region_check #(
        .REGION_BASE (REGION_BASE),
        .REGION_MASK (REGION_MASK)
    ) u_region_check (
        .addr_i      (fe0_addr),
        .violation_o (violation)
    );

    fetch_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .s_flush_i     (s_flush_i),
        .push_i        (push),
        .push_data_i   (push_data),
        .push_status_i (push_status),
        .s_stall_i     (s_stall_i),
        .s_instr_o     (s_instr_o),
        .s_status_o    (s_status_o),
        .s_valid_o     (s_valid_o),
        .space_first_o (space_first),
        .space_one_o   (space_one),
        .space_two_o   (space_two),
        .space_three_o (space_three)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f fetch_stage.f --top-module fetch_stage_tb \
    -Mdir obj_dir -o fetch_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* test/fetch_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none
//**************************************************************************
// Fetch stage testbench
// AHB-Lite memory model with wait states and an error window, redirects,
// decode stalls and assertions against a reference fetch address
//**************************************************************************

module fetch_stage_tb;

    localparam logic [31:0] RESET_ADDR   = 32'h0000_0100;
    localparam logic [31:0] REGION_BASE  = 32'h0000_0000;
    localparam logic [31:0] REGION_MASK  = 32'hFFFF_0000;  // Region is the low 64 KiB
    localparam logic [31:0] DATA_PATTERN = 32'h5A5A_0000;
    localparam logic [31:0] SEED         = 32'h501a_58c0;

    logic                     clk = 1'b0;
    logic                     rst_n = 1'b0;
    logic                     flush = 1'b0;
    logic [31:0]              toc_addr = '0;
    logic                     stall = 1'b0;
    logic                     hready = 1'b1;
    logic                     hresp = 1'b0;
    logic [31:0]              hrdata = '0;
    logic [31:0]              haddr;
    logic [1:0]               htrans;
    logic [31:0]              instr;
    fetch_pkg::fetch_status_t status;
    logic                     valid;
    logic                     consume;       // Decode takes the head this cycle

    logic [29:0]              exp_waddr;     // Reference fetch address
    logic [31:0]              exp_instr;
    fetch_pkg::fetch_status_t exp_status;
    logic [31:0]              prev_haddr;
    logic [31:0]              prev_instr;
    fetch_pkg::fetch_status_t prev_status;
    logic                     dp_valid;      // Memory has a data phase open
    logic [29:0]              dp_waddr;
    logic [31:0]              mem_rnd = SEED;
    logic [31:0]              stall_rnd = SEED;
    int                       wait_left;
    int                       wait_mode = 0; // 0 none, 1 random, 2 three per transfer
    int                       consumed = 0;
    int                       word_errs = 0;
    int                       bus_errs = 0;
    int                       region_errs = 0;
    int                       stall_errs = 0;
    int                       timeout_errs = 0;
    int                       test_count = 0;
    int                       err_base = 0;
    bit                       timed_out = 1'b0;
    string                    test_name = "reset";

    fetch_stage #(
        .FIFO_DEPTH  (4),
        .RESET_ADDR  (RESET_ADDR),
        .REGION_BASE (REGION_BASE),
        .REGION_MASK (REGION_MASK)
    ) DUT (
        .s_clk_i      (clk),
        .rst_n_i      (rst_n),
        .s_flush_i    (flush),
        .s_toc_addr_i (toc_addr),
        .s_stall_i    (stall),
        .s_hready_i   (hready),
        .s_hresp_i    (hresp),
        .s_hrdata_i   (hrdata),
        .s_haddr_o    (haddr),
        .s_htrans_o   (htrans),
        .s_instr_o    (instr),
        .s_status_o   (status),
        .s_valid_o    (valid)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic in_region(input logic [31:0] addr);
        return (addr & REGION_MASK) == REGION_BASE;
    endfunction

    // Four words at byte address 0x200 answer with an error
    function automatic logic in_err_window(input logic [29:0] waddr);
        return (waddr >= 30'h80) && (waddr <= 30'h83);
    endfunction

    function automatic int total_errors();
        return word_errs + bus_errs + region_errs + stall_errs + timeout_errs;
    endfunction

    always #10 clk = ~clk;

    assign consume = valid && !stall && !flush;

    // Expected head word for the reference address
    always_comb begin
        if (!in_region({exp_waddr, 2'b00})) begin
            exp_instr  = '0;                              // No bus data outside the region
            exp_status = fetch_pkg::FETCH_PMA_VIOL;
        end else begin
            exp_instr  = {2'b00, exp_waddr} ^ DATA_PATTERN;
            exp_status = in_err_window(exp_waddr) ? fetch_pkg::FETCH_BUS_ERR
                                                  : fetch_pkg::FETCH_VALID;
        end
    end

    always @(posedge clk) begin
        prev_haddr  <= haddr;
        prev_instr  <= instr;
        prev_status <= status;
        if (!rst_n) begin
            exp_waddr <= RESET_ADDR[31:2];
        end else if (flush) begin
            exp_waddr <= toc_addr[31:2];                  // New path starts at the target
        end else if (consume) begin
            exp_waddr <= exp_waddr + 30'd1;
            consumed  <= consumed + 1;
        end
    end

    // Memory slave with one data phase after each accepted NONSEQ
    always @(posedge clk) begin
        if (!rst_n) begin
            dp_valid = 1'b0;
            dp_waddr = '0;
            wait_left = 0;
            hready <= 1'b1;
            hresp  <= 1'b0;
            hrdata <= '0;
        end else begin
            if (hready) begin                             // Address phase accepted
                dp_valid = (htrans == fetch_pkg::HTRANS_NONSEQ);
                dp_waddr = haddr[31:2];
                if (!dp_valid || wait_mode == 0) begin
                    wait_left = 0;
                end else if (wait_mode == 2) begin
                    wait_left = 3;
                end else begin
                    mem_rnd = next_random(mem_rnd);
                    wait_left = mem_rnd[3] ? int'(mem_rnd[1:0]) : 0;
                end
            end else if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end
            hready <= (wait_left == 0);
            hrdata <= {2'b00, dp_waddr} ^ DATA_PATTERN;
            hresp  <= dp_valid && in_err_window(dp_waddr);
        end
    end

    a_word: assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> (instr == exp_instr && status == exp_status))
        else begin
            $display("CHECK FAILED %s: head expected %h status %0d, actual %h status %0d",
                     test_name, $sampled(exp_instr), $sampled(exp_status),
                     $sampled(instr), $sampled(status));
            word_errs++;
        end

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans == fetch_pkg::HTRANS_NONSEQ && !hready) |=>
        (haddr == prev_haddr && htrans == fetch_pkg::HTRANS_NONSEQ))
        else begin
            $display("CHECK FAILED %s: held request expected %h trans 2, actual %h trans %0d",
                     test_name, $sampled(prev_haddr), $sampled(haddr), $sampled(htrans));
            bus_errs++;
        end

    a_region: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans == fetch_pkg::HTRANS_NONSEQ) |-> in_region(haddr))
        else begin
            $display("CHECK FAILED %s: trans at %h expected %0d, actual %0d",
                     test_name, $sampled(haddr), fetch_pkg::HTRANS_IDLE, $sampled(htrans));
            region_errs++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && valid && !flush) |=>
        (valid && instr == prev_instr && status == prev_status))
        else begin
            $display("CHECK FAILED %s: stalled head expected %h status %0d, actual %h status %0d",
                     test_name, $sampled(prev_instr), $sampled(prev_status),
                     $sampled(instr), $sampled(status));
            stall_errs++;
        end

    task automatic start_test(input string name);
        test_name = name;
        err_base  = total_errors();
    endtask

    task automatic end_test();
        int errs;
        errs = total_errors() - err_base;
        test_count++;
        if (errs == 0) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, errs);
    endtask

    // Starts on a rising edge and holds the flush for one cycle
    task automatic redirect(input logic [31:0] target);
        flush    <= 1'b1;
        toc_addr <= target;
        @(posedge clk);
        flush    <= 1'b0;
    endtask

    task automatic wait_for_words(input int n);
        int target;
        int cycles;
        target = consumed + n;
        cycles = 0;
        while (!timed_out && consumed < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > 1000) begin
                $display("Timeout in test %s, only %0d of %0d words were delivered",
                         test_name, consumed - (target - n), n);
                timed_out = 1'b1;
                timeout_errs++;
            end
        end
    endtask

    // First wait cycle of a transfer while the next request is already out
    task automatic wait_for_wait_state();
        int   cycles;
        logic last_ready;
        cycles = 0;
        last_ready = 1'b0;
        while (!timed_out) begin
            @(posedge clk);
            if (!hready && last_ready && htrans == fetch_pkg::HTRANS_NONSEQ) break;
            last_ready = hready;
            cycles++;
            if (cycles > 200) begin
                $display("Timeout in test %s, no wait state seen on the bus", test_name);
                timed_out = 1'b1;
                timeout_errs++;
            end
        end
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d words checked, %0d errors",
                 test_count, consumed, total_errors());
        if (total_errors() == 0) $display("ALL TESTS PASSED");
        else $display("SOME TESTS FAILED");
        $finish;
    endtask

    initial begin
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        start_test("sequential");
        wait_for_words(16);
        end_test();

        start_test("wait_states");
        wait_mode <= 1;
        wait_for_words(24);
        end_test();

        start_test("redirect");
        redirect(32'h0000_0800);
        wait_for_words(8);
        wait_mode <= 2;
        wait_for_wait_state();
        redirect(32'h0000_0C00);                         // Lands in the second wait cycle
        wait_for_words(8);
        wait_mode <= 1;
        end_test();

        start_test("bus_error");
        redirect(32'h0000_01F0);                         // Runs through the error window
        wait_for_words(12);
        end_test();

        start_test("region_violation");
        redirect(32'h0002_0000);
        wait_for_words(4);
        redirect(32'h0000_0400);
        wait_for_words(4);
        end_test();

        start_test("decode_stall");
        stall <= 1'b1;
        repeat (10) @(posedge clk);                      // Long enough to fill the buffer
        for (int i = 0; i < 40; i++) begin
            stall_rnd = next_random(stall_rnd);
            stall <= stall_rnd[0];
            @(posedge clk);
        end
        stall <= 1'b0;
        wait_for_words(12);
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire
